/* ht_ctrl.sv */
`timescale 1ns/1ps
`include "ht_params.svh"

module ht_ctrl import ht_pkg::*; (
	input  logic                 rst,
	input  logic                 clk,
	input  logic                 cs,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic [`HT_KEY_W+1:0] adr,
	input  logic [31:0]          dat_i,
	input  logic                 wea,
	input  logic [`HT_IDX_W-1:0] home_idx,
	input  logic [31:0]          ram_rdata,
	output ht_state_e            state,
	output logic [`HT_KEY_W-1:0] key,
	output logic [`HT_IDX_W-1:0] ram_addr,
	output logic                 ram_wr,
	output logic [31:0]          ram_wdata,
	output logic [31:0]          dat_o,
	output logic                 ack,
	output logic                 err
);

	// Probe counter wide enough to count HT_PROBES slots
	localparam int PROBE_W = $clog2(`HT_PROBES);
	localparam logic [PROBE_W-1:0] PROBE_LAST = PROBE_W'(`HT_PROBES - 1);

	logic                 req_valid;
	logic                 busy;
	logic                 key_match;
	logic [`HT_IDX_W-1:0] clr_idx;
	logic [`HT_IDX_W-1:0] probe_idx;
	logic [PROBE_W-1:0]   probe_cnt;
	logic [`HT_VAL_W-1:0] value;
	logic                 slot_found;
	ht_entry_u            rd_entry;
	ht_entry_u            hit_entry;
	ht_entry_u            wr_entry;

	assign req_valid = cs & cyc & stb;

	// States in which an access holds the bus and may be abandoned
	assign busy = (state == ST_HASH) || (state == ST_READ) ||
		(state == ST_COMPARE) || (state == ST_COMMIT);

	// Slot word returned by the memory, decoded into its fields
	assign rd_entry = ht_entry_u'(ram_rdata);

	// A live slot holding our key
	assign key_match = rd_entry.fields.valid && (rd_entry.fields.key == key);

	// New entry for an insert or an update in place
	always_comb begin
		wr_entry.fields.valid = 1'b1;
		wr_entry.fields.key = key;
		wr_entry.fields.value = value;
	end

	// ======================================================================
	// Memory port
	// ======================================================================

	// The sweep owns the port while it runs, otherwise the probe index does
	always_comb begin
		ram_addr = probe_idx;
		ram_wr = 1'b0;
		ram_wdata = wr_entry.raw;
		if (state == ST_CLEAR) begin
			ram_addr = clr_idx;
			ram_wr = 1'b1;
			ram_wdata = '0;
		end else if (state == ST_COMMIT) begin
			// Write only when a slot was found and the master still waits
			ram_wr = wea & slot_found & req_valid;
		end
	end

	// ======================================================================
	// Sequencer
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_CLEAR;
			clr_idx <= '0;
			ack <= 1'b0;
			err <= 1'b0;
		end else if (busy && !req_valid) begin
			// Strobe withdrawn, so drop the access without ack and without a write
			state <= ST_IDLE;
		end else begin
			// Ack and err last only for the ST_ACK cycle
			ack <= 1'b0;
			err <= 1'b0;
			case (state)
			ST_CLEAR: begin
				// One slot per cycle, the last slot moves on
				clr_idx <= clr_idx + 1'b1;
				if (&clr_idx)
					state <= ST_CLEAR_DONE;
			end
			ST_CLEAR_DONE: state <= ST_IDLE;
			ST_IDLE: begin
				// Take the key and the value once, the bus may change later
				if (req_valid) begin
					key <= adr[`HT_KEY_W+1:2];
					value <= dat_i[`HT_VAL_W-1:0];
					state <= ST_HASH;
				end
			end
			ST_HASH: begin
				// The hash settles from the latched key during this cycle
				probe_idx <= home_idx;
				probe_cnt <= '0;
				state <= ST_READ;
			end
			ST_READ: state <= ST_COMPARE;
			ST_COMPARE: begin
				// Keep the slot word for a read only when it is our key
				hit_entry.raw <= key_match ? rd_entry.raw : '0;
				if (key_match || !rd_entry.fields.valid) begin
					// Our key or an empty slot ends the probe run
					slot_found <= 1'b1;
					state <= ST_COMMIT;
				end else if (probe_cnt == PROBE_LAST) begin
					slot_found <= 1'b0;
					state <= ST_COMMIT;
				end else begin
					// Linear probing wraps around the end of the table
					probe_idx <= probe_idx + 1'b1;
					probe_cnt <= probe_cnt + 1'b1;
					state <= ST_READ;
				end
			end
			ST_COMMIT: begin
				// An insert into a full probe run is refused
				if (wea && !slot_found)
					err <= 1'b1;
				else
					ack <= 1'b1;
				// Reads return the entry, or zero when the key is absent
				if (!wea)
					dat_o <= hit_entry.raw;
				state <= ST_ACK;
			end
			ST_ACK: state <= ST_IDLE;
			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* ht_hash.sv */
`timescale 1ns/1ps
`include "ht_params.svh"

module ht_hash (
	input  logic [`HT_KEY_W-1:0] key,
	output logic [`HT_IDX_W-1:0] home_idx
);

	// The key is cut into three 6-bit slices
	logic [`HT_IDX_W-1:0] slice_lo;
	logic [`HT_IDX_W-1:0] slice_mid;
	logic [`HT_IDX_W-1:0] slice_hi;

	// Low slice covers key bits 5 to 0
	assign slice_lo = key[5:0];

	// Middle slice covers key bits 11 to 6
	assign slice_mid = key[11:6];

	// Only three key bits are left for the top slice, padded with zeros
	assign slice_hi = {3'b000, key[14:12]};

	// Folding by exclusive-or spreads keys that differ in any slice
	// Linear probing starts at this index
	assign home_idx = slice_lo ^ slice_mid ^ slice_hi;

endmodule

/* ht_params.svh */
`ifndef HT_PARAMS_SVH
`define HT_PARAMS_SVH

// Table geometry for the hash table
// The index width sets the slot count, so 6 bits gives 64 slots
`define HT_IDX_W 6

// Key taken from the bus address, bits 16 down to 2
`define HT_KEY_W 15

// Value stored under each key, the low half of the write data
`define HT_VAL_W 16

// Longest run of slots that one access may probe
// An insert that reaches this limit without a free slot ends in err
`define HT_PROBES 8

`endif

/* ht_pkg.sv */
package ht_pkg;

	// Controller states
	// The encoding is fixed because the write tracker decodes it as well
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_HASH       = 3'd1,
		ST_READ       = 3'd2,
		ST_COMPARE    = 3'd3,
		ST_COMMIT     = 3'd4,
		ST_ACK        = 3'd5,
		ST_CLEAR      = 3'd6,
		ST_CLEAR_DONE = 3'd7
	} ht_state_e;

	// One table slot as the controller sees it
	// Valid sits in the top bit so a zero word is an empty slot
	typedef struct packed {
		logic        valid;
		logic [14:0] key;
		logic [15:0] value;
	} ht_entry_t;

	// The same 32-bit slot word seen two ways
	// Memory and bus move the raw word, compare and build use the fields
	typedef union packed {
		logic [31:0] raw;
		ht_entry_t   fields;
	} ht_entry_u;

endpackage

/* ht_props.sv */
`timescale 1ns/1ps

module ht_props import ht_pkg::*; (
	input logic      clk,
	input logic      rst,
	input ht_state_e state,
	input logic      ack,
	input logic      err,
	input logic      ram_wr
);

	// Number of assertion failures seen so far
	int   assert_failures = 0;
	// Set once the clear sweep has finished for the first time
	logic clear_done_seen;

	always_ff @(posedge clk) begin
		if (rst)
			clear_done_seen <= 1'b0;
		else if (state == ST_CLEAR_DONE)
			clear_done_seen <= 1'b1;
	end

	// ======================================================================
	// Bus handshake
	// ======================================================================

	// A request ends either with ack or with err, never with both
	a_ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack && err))
	else begin
		$error("ack and err are high in the same cycle");
		assert_failures = assert_failures + 1;
	end

	// Each response is a single-cycle pulse
	a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
	else begin
		$error("ack stayed high for more than one cycle");
		assert_failures = assert_failures + 1;
	end

	a_err_pulse: assert property (@(posedge clk) disable iff (rst) err |=> !err)
	else begin
		$error("err stayed high for more than one cycle");
		assert_failures = assert_failures + 1;
	end

	// Nothing is acknowledged while the table is still being cleared
	a_no_early_ack: assert property (@(posedge clk) disable iff (rst) ack |-> clear_done_seen)
	else begin
		$error("ack seen before the clear sweep finished");
		assert_failures = assert_failures + 1;
	end

	// ======================================================================
	// Memory writes
	// ======================================================================

	// Only the commit cycle and the sweep may write the table
	a_wr_state: assert property (@(posedge clk) disable iff (rst)
		ram_wr |-> (state == ST_COMMIT || state == ST_CLEAR))
	else begin
		$error("ram_wr high outside ST_COMMIT and ST_CLEAR");
		assert_failures = assert_failures + 1;
	end

endmodule

bind ht_ctrl ht_props u_props (
	.clk    (clk),
	.rst    (rst),
	.state  (state),
	.ack    (ack),
	.err    (err),
	.ram_wr (ram_wr)
);

/* ht_ram.sv */
`timescale 1ns/1ps
`include "ht_params.svh"

module ht_ram import ht_pkg::*; (
	input  logic                 clk,
	input  logic [`HT_IDX_W-1:0] addr,
	input  logic                 wr,
	input  logic [31:0]          wdata,
	output logic [31:0]          rdata
);

	// One entry word per slot
	ht_entry_u mem [0:(1 << `HT_IDX_W) - 1];

	// Single port, so a read and a write in one cycle share the address
	// Nonblocking assignment makes the port read-first, the old word comes out
	always_ff @(posedge clk) begin
		if (wr)
			mem[addr].raw <= wdata;
		// Read data is registered every cycle whether or not it is wanted
		rdata <= mem[addr].raw;
	end

endmodule

/* ht_top.f */
+incdir+.
ht_hash.sv
ht_pkg.sv
ht_ram.sv
ht_wea.sv
ht_ctrl.sv
ht_top.sv
ht_props.sv
tb_ht_top.sv

/* ht_top.sv */
`timescale 1ns/1ps
`include "ht_params.svh"

module ht_top import ht_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cs,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [`HT_KEY_W+1:0] adr,
	input  logic [31:0]          dat_i,
	output logic [31:0]          dat_o,
	output logic                 ack,
	output logic                 err
);

	// ======================================================================
	// Internal nets
	// ======================================================================

	// Controller state, decoded by the write tracker
	ht_state_e            state;
	// Registered write intention of the current access
	logic                 wea;
	// Latched key and its home slot
	logic [`HT_KEY_W-1:0] key;
	logic [`HT_IDX_W-1:0] home_idx;
	// Table memory port
	logic [`HT_IDX_W-1:0] ram_addr;
	logic                 ram_wr;
	logic [31:0]          ram_wdata;
	logic [31:0]          ram_rdata;

	// ======================================================================
	// Blocks
	// ======================================================================

	// Sweep, probe and bus acknowledge sequencing
	ht_ctrl u_ctrl (
		.rst       (rst),
		.clk       (clk),
		.cs        (cs),
		.cyc       (cyc),
		.stb       (stb),
		.adr       (adr),
		.dat_i     (dat_i),
		.wea       (wea),
		.home_idx  (home_idx),
		.ram_rdata (ram_rdata),
		.state     (state),
		.key       (key),
		.ram_addr  (ram_addr),
		.ram_wr    (ram_wr),
		.ram_wdata (ram_wdata),
		.dat_o     (dat_o),
		.ack       (ack),
		.err       (err)
	);

	// Tracks whether this access writes, cancelled when the strobe goes away
	ht_wea u_wea (
		.rst   (rst),
		.clk   (clk),
		.state (state),
		.cs    (cs),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.wea   (wea)
	);

	ht_hash u_hash (
		.key      (key),
		.home_idx (home_idx)
	);

	ht_ram u_ram (
		.clk   (clk),
		.addr  (ram_addr),
		.wr    (ram_wr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

/* ht_wea.sv */
`timescale 1ns/1ps

module ht_wea import ht_pkg::*; (
	input  logic      rst,
	input  logic      clk,
	input  ht_state_e state,
	input  logic      cs,
	input  logic      cyc,
	input  logic      stb,
	input  logic      we,
	output logic      wea
);

	logic req_valid;

	// A request counts only while all three bus qualifiers are high
	assign req_valid = cs & cyc & stb;

	// Write intention of the access in progress
	always_ff @(posedge clk) begin
		if (rst) begin
			wea <= 1'b0;
		end else begin
			case (state)
			// Sample the bus direction once the probe address goes out
			ST_READ:       wea <= we;
			// A master that let go of the bus no longer wants the write
			ST_COMMIT:
				if (!req_valid)
					wea <= 1'b0;
			// The sweep is one long write of empty words
			ST_CLEAR:      wea <= 1'b1;
			ST_CLEAR_DONE: wea <= 1'b0;
			default:       ;
			endcase
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the hash table testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f ht_top.f --top-module tb_ht_top \
	-o sim_tb_ht_top; then
	echo "Verilator build failed"
	exit 1
fi

# Assertion errors must not stop the run before the summary line
output=$(./obj_dir/sim_tb_ht_top +verilator+error+limit+1000)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

/* tb_ht_top.sv */
`timescale 1ns/1ps
`include "ht_params.svh"

module tb_ht_top;

	localparam int SLOTS = 1 << `HT_IDX_W;
	// Sweep of every slot plus the ST_CLEAR_DONE cycle
	localparam int CLEAR_CYCLES = SLOTS + 1;
	// Hash cycle, a read and compare per probe, commit and ack
	localparam int LONGEST_ACCESS = 3 + 2 * `HT_PROBES;
	// Bus accesses of all tests, the two aborted writes included
	localparam int NUM_ACCESSES = 20 + 80 + 20 + (`HT_PROBES + 2) + 4;
	localparam int CYCLE_LIMIT = NUM_ACCESSES * 200 + CLEAR_CYCLES + 3;

	logic        clk = 1'b0;
	logic        rst;
	logic        cs;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [16:0] adr;
	logic [31:0] dat_i;
	logic [31:0] dat_o;
	logic        ack;
	logic        err;

	// Reference table that starts with every slot empty, like the swept DUT
	logic        model_valid [SLOTS];
	logic [14:0] model_key [SLOTS];
	logic [15:0] model_val [SLOTS];

	logic [31:0] rng_state;
	int          cycle_count = 0;
	int          checks = 0;
	int          value_errors = 0;
	int          handshake_errors = 0;

	always #20 clk = ~clk;

	ht_top u_dut (
		.clk   (clk),
		.rst   (rst),
		.cs    (cs),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack   (ack),
		.err   (err)
	);

	// Hard stop if the DUT never answers
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped answering the bus", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Linear congruential generator that takes one step per call
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Home slot is the exclusive-or of the three key slices
	function automatic logic [5:0] fold_key(input logic [14:0] k);
		return k[5:0] ^ k[11:6] ^ {3'b000, k[14:12]};
	endfunction

	// Walks the probe window and stops at the key or at the first empty slot
	function automatic logic find_slot(input logic [14:0] k, output logic [5:0] slot);
		logic [5:0] idx;
		idx = fold_key(k);
		slot = idx;
		for (int p = 0; p < `HT_PROBES; p++) begin
			if (!model_valid[idx] || model_key[idx] == k) begin
				slot = idx;
				return 1'b1;
			end
			idx = idx + 6'd1;
		end
		return 1'b0;
	endfunction

	// Word a read of this key should return, zero when the key is absent
	function automatic logic [31:0] model_read(input logic [14:0] k);
		logic [5:0] slot;
		if (find_slot(k, slot) && model_valid[slot])
			return {1'b1, k, model_val[slot]};
		return 32'd0;
	endfunction

	function automatic int count_occupied();
		int n;
		n = 0;
		for (int i = 0; i < SLOTS; i++)
			if (model_valid[6'(i)])
				n++;
		return n;
	endfunction

	// Live slots in the DUT table memory, found by their valid bits
	function automatic int dut_entry_count();
		int n;
		n = 0;
		for (int i = 0; i < SLOTS; i++)
			if (u_dut.u_ram.mem[i].fields.valid)
				n++;
		return n;
	endfunction

	// ======================================================================
	// Bus tasks
	// ======================================================================

	// One complete Wishbone access, held until ack or err
	task automatic bus_access(input logic write, input logic [14:0] k, input logic [15:0] v,
			output logic got_ack, output logic got_err, output logic [31:0] rdata);
		logic [31:0] r;
		r = next_random();
		@(posedge clk);
		#2;
		cs = 1'b1;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = {k, 2'b00};
		// Upper data half is noise that the DUT must ignore
		dat_i = {r[31:16], v};
		do begin
			@(posedge clk);
			#2;
		end while (!ack && !err);
		got_ack = ack;
		got_err = err;
		rdata = dat_o;
		cs = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	// Insert or update, with ack or err predicted by the model
	task automatic write_check(input string name, input logic [14:0] k, input logic [15:0] v,
			output logic accepted);
		logic [5:0]  slot;
		logic        got_ack;
		logic        got_err;
		logic [31:0] rdata;
		accepted = find_slot(k, slot);
		bus_access(1'b1, k, v, got_ack, got_err, rdata);
		checks++;
		if (got_ack !== accepted || got_err !== !accepted) begin
			$display("FAILED %s key %h: expected ack %b err %b, actual ack %b err %b",
				name, k, accepted, !accepted, got_ack, got_err);
			handshake_errors++;
		end
		if (accepted) begin
			model_valid[slot] = 1'b1;
			model_key[slot] = k;
			model_val[slot] = v;
		end
	endtask

	task automatic read_check(input string name, input logic [14:0] k);
		logic [31:0] expected;
		logic        got_ack;
		logic        got_err;
		logic [31:0] rdata;
		expected = model_read(k);
		bus_access(1'b0, k, 16'h0000, got_ack, got_err, rdata);
		checks++;
		if (!got_ack || got_err) begin
			$display("Read of key %h in %s ended with err instead of ack", k, name);
			handshake_errors++;
		end else if (rdata !== expected) begin
			$display("FAILED %s key %h: expected %h, actual %h", name, k, expected, rdata);
			value_errors++;
		end
	endtask

	// Write whose strobe goes away one cycle after the DUT took it
	task automatic abort_write(input logic [14:0] k, input logic [15:0] v);
		logic answered;
		answered = 1'b0;
		@(posedge clk);
		#2;
		cs = 1'b1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = {k, 2'b00};
		dat_i = {16'h0000, v};
		// The idle controller takes the request at this edge
		@(posedge clk);
		@(posedge clk);
		#2;
		stb = 1'b0;
		// Watch longer than the slowest possible access
		repeat (LONGEST_ACCESS + 4) begin
			@(posedge clk);
			#2;
			if (ack || err)
				answered = 1'b1;
		end
		cs = 1'b0;
		cyc = 1'b0;
		we = 1'b0;
		checks++;
		if (answered) begin
			$display("Aborted write of key %h still got ack or err", k);
			handshake_errors++;
		end
	endtask

	// Random key that the model does not hold yet
	task automatic pick_fresh_key(output logic [14:0] k);
		logic [31:0] r;
		r = next_random();
		k = r[30:16];
		while (model_read(k) != 32'd0) begin
			r = next_random();
			k = r[30:16];
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [31:0] r;
		logic [14:0] k;
		logic [15:0] v;
		logic        accepted;
		logic        fresh;
		logic [5:0]  home;
		int          free_slots;
		int          best_free;
		int          occupied_before;
		int          occupied_after;
		int          total_errors;
		logic [14:0] inserted_keys [$];
		logic [14:0] chain_keys [$];

		rng_state = 32'hc155_e321;
		rst = 1'b1;
		cs = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_i = '0;
		for (int i = 0; i < SLOTS; i++) begin
			model_valid[6'(i)] = 1'b0;
			model_key[6'(i)] = '0;
			model_val[6'(i)] = '0;
		end

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		// The table is ready once the sweep and ST_CLEAR_DONE are over
		repeat (CLEAR_CYCLES) @(posedge clk);

		// Every slot must read back as empty
		for (int i = 0; i < 20; i++) begin
			r = next_random();
			read_check("clear_sweep", r[30:16]);
		end

		// Random inserts where a repeated key becomes an update in the model as well
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			inserted_keys.push_back(r[30:16]);
			write_check("insert", r[30:16], r[15:0], accepted);
		end
		foreach (inserted_keys[i])
			read_check("insert_readback", inserted_keys[i]);

		// Updates in place leave the slot count alone
		occupied_before = count_occupied();
		for (int i = 0; i < 10; i++) begin
			r = next_random();
			write_check("rewrite", inserted_keys[i * 4], r[15:0], accepted);
		end
		for (int i = 0; i < 10; i++)
			read_check("rewrite_readback", inserted_keys[i * 4]);
		// A duplicate entry in the DUT would raise its live slot count
		occupied_after = dut_entry_count();
		checks++;
		if (occupied_after != occupied_before) begin
			$display("FAILED rewrite_occupancy: expected %0d, actual %0d",
				occupied_before, occupied_after);
			value_errors++;
		end

		// Home index with the emptiest probe window
		best_free = -1;
		home = '0;
		for (int h = 0; h < SLOTS; h++) begin
			free_slots = 0;
			for (int p = 0; p < `HT_PROBES; p++)
				if (!model_valid[6'(h + p)])
					free_slots++;
			if (free_slots > best_free) begin
				best_free = free_slots;
				home = 6'(h);
			end
		end

		// Distinct new keys that all fold onto that home index
		while (chain_keys.size() < `HT_PROBES + 1) begin
			r = next_random();
			k = {r[24:16], 6'b000000};
			k[5:0] = home ^ k[11:6] ^ {3'b000, k[14:12]};
			fresh = (model_read(k) == 32'd0);
			foreach (chain_keys[j])
				if (chain_keys[j] == k)
					fresh = 1'b0;
			if (fresh)
				chain_keys.push_back(k);
		end
		foreach (chain_keys[j]) begin
			r = next_random();
			write_check($sformatf("chain_insert_%0d", j), chain_keys[j], r[15:0], accepted);
		end
		read_check("chain_refused", chain_keys[`HT_PROBES]);

		// Cancelled writes keep the old entry, or leave the key absent
		r = next_random();
		abort_write(inserted_keys[5], r[15:0]);
		read_check("abort_existing", inserted_keys[5]);
		pick_fresh_key(k);
		r = next_random();
		v = r[15:0];
		abort_write(k, v);
		read_check("abort_fresh", k);

		total_errors = value_errors + handshake_errors + u_dut.u_ctrl.u_props.assert_failures;
		$display("Checks %0d, value errors %0d, handshake errors %0d, assertion failures %0d",
			checks, value_errors, handshake_errors, u_dut.u_ctrl.u_props.assert_failures);
		if (total_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
